/* verilog/ex_pkg.sv */
/*
 * Shared widths, encodings and the writeback bundle of the RV64I execute stage.
 * The ALU operation codes follow the funct3 field of the base ISA.
 * Hold levels are ordered, so a numeric compare tells whether a stage freezes.
 */
`default_nettype none

package ex_pkg;

	// Register and memory widths of the core.
	localparam int XLEN      = 64;
	localparam int ADDR_W    = 64;
	localparam int REG_IDX_W = 5;

	// One strobe bit per data byte.
	localparam int STRB_W    = XLEN / 8;

	// Base ALU operations, encoded as funct3.
	// ADD doubles as SUB and SRL doubles as SRA through separate select bits.
	typedef enum logic [2:0] {
		ALU_ADD  = 3'd0,
		ALU_SLL  = 3'd1,
		ALU_SLT  = 3'd2,
		ALU_SLTU = 3'd3,
		ALU_XOR  = 3'd4,
		ALU_SRL  = 3'd5,
		ALU_OR   = 3'd6,
		ALU_AND  = 3'd7
	} alu_op_e;

	// Load type as decoded in ID.
	// The unsigned codes zero-extend and the others sign-extend.
	typedef enum logic [2:0] {
		LOAD_NONE = 3'd0,
		LOAD_LB   = 3'd1,
		LOAD_LH   = 3'd2,
		LOAD_LW   = 3'd3,
		LOAD_LD   = 3'd4,
		LOAD_LBU  = 3'd5,
		LOAD_LHU  = 3'd6,
		LOAD_LWU  = 3'd7
	} load_code_e;

	// Store type, which fixes the access size in bytes.
	typedef enum logic [2:0] {
		STORE_NONE = 3'd0,
		STORE_SB   = 3'd1,
		STORE_SH   = 3'd2,
		STORE_SW   = 3'd3,
		STORE_SD   = 3'd4
	} store_code_e;

	// Hold level from the hazard logic.
	// A level freezes its own stage and every stage before it.
	typedef enum logic [2:0] {
		HOLD_NONE = 3'd0,
		HOLD_IF   = 3'd1,
		HOLD_ID   = 3'd2,
		HOLD_EX   = 3'd3,
		HOLD_MEM  = 3'd4,
		HOLD_WB   = 3'd5
	} hold_code_e;

	// The EX/MEM register freezes at this level and above.
	localparam hold_code_e HOLD_CODE_EX = HOLD_EX;

	// Bundle that leaves EX/MEM toward writeback.
	typedef struct packed {
		logic [XLEN-1:0]      alu_result;
		logic [XLEN-1:0]      data_reg_wr;
		logic [REG_IDX_W-1:0] addr_reg_wr;
		logic                 reg_wr_en;
	} wb_bus_t;

endpackage

`default_nettype wire

/* verilog/ex_alu.sv */
/*
 * Purely combinational integer ALU for RV64I, no multiply or divide.
 * Word mode works on the low 32 bits and sign-extends the result from bit 31.
 * The address sum is always num1 + num2, independent of the subtract select.
 */
`timescale 1ns/1ps
`default_nettype none

module ex_alu import ex_pkg::*; (
	input  logic [XLEN-1:0] alu_op_num1_i,
	input  logic [XLEN-1:0] alu_op_num2_i,
	input  alu_op_e         alu_operation_i,
	input  logic            alu_add_sub_i,
	input  logic            alu_shift_i,
	input  logic            word_intercept_i,
	output logic [XLEN-1:0] alu_result_o,
	output logic [XLEN-1:0] alu_sum_o
);

	logic [XLEN-1:0] op1;
	logic [XLEN-1:0] op2;
	logic [5:0]      shamt;
	logic [XLEN-1:0] res_add;
	logic [XLEN-1:0] res_shr;
	logic [XLEN-1:0] res;
	logic            srl_word;

	// The effective address never uses the subtract select.
	assign alu_sum_o = alu_op_num1_i + alu_op_num2_i;

	// A logical right shift in word mode needs zeros above bit 31,
	// so that they cannot shift down into the kept half.
	assign srl_word = (alu_operation_i == ALU_SRL) && !alu_shift_i;

	// In word mode both operands are rebuilt from their low halves.
	// Sign extension keeps signed and unsigned order of the 32-bit values,
	// so the compares need no separate word datapath.
	always_comb begin
		if (word_intercept_i) begin
			if (srl_word) begin
				op1 = {32'b0, alu_op_num1_i[31:0]};
			end else begin
				op1 = {{32{alu_op_num1_i[31]}}, alu_op_num1_i[31:0]};
			end
			op2   = {{32{alu_op_num2_i[31]}}, alu_op_num2_i[31:0]};
			shamt = {1'b0, alu_op_num2_i[4:0]};
		end else begin
			op1   = alu_op_num1_i;
			op2   = alu_op_num2_i;
			shamt = alu_op_num2_i[5:0];
		end
	end

	// Adder shared by ADD and SUB.
	assign res_add = alu_add_sub_i ? (op1 - op2) : (op1 + op2);

	// Right shifter, arithmetic when alu_shift_i is set.
	assign res_shr = alu_shift_i ? XLEN'($signed(op1) >>> shamt) : (op1 >> shamt);

	always_comb begin
		case (alu_operation_i)
			ALU_ADD:  res = res_add;
			ALU_SLL:  res = op1 << shamt;
			ALU_SLT:  res = {{(XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
			ALU_SLTU: res = {{(XLEN-1){1'b0}}, op1 < op2};
			ALU_XOR:  res = op1 ^ op2;
			ALU_SRL:  res = res_shr;
			ALU_OR:   res = op1 | op2;
			ALU_AND:  res = op1 & op2;
			default:  res = '0;
		endcase
	end

	// Word results keep only the low half, sign-extended.
	always_comb begin
		if (word_intercept_i) begin
			alu_result_o = {{32{res[31]}}, res[31:0]};
		end else begin
			alu_result_o = res;
		end
	end

endmodule

`default_nettype wire

/* verilog/ex_lsu_req.sv */
/*
 * Combinational data memory request former.
 * Misaligned accesses are not trapped; the strobe simply shifts past byte 7
 * and loses the upper bytes. Store data is placed on its byte lanes.
 */
`timescale 1ns/1ps
`default_nettype none

module ex_lsu_req import ex_pkg::*; (
	input  logic [ADDR_W-1:0] addr_i,
	input  logic [XLEN-1:0]   data_rs2_i,
	input  load_code_e        load_code_i,
	input  store_code_e       store_code_i,
	output logic              mem_wr_en_o,
	output logic              mem_rd_en_o,
	output logic [XLEN-1:0]   data_mem_wr_o,
	output logic [STRB_W-1:0] strb_mem_wr_o,
	output logic [ADDR_W-1:0] addr_mem_wr_o,
	output logic [ADDR_W-1:0] addr_mem_rd_o
);

	logic [2:0]        offset;
	logic [STRB_W-1:0] size_mask;

	// Byte position inside the doubleword.
	assign offset = addr_i[2:0];

	// Contiguous byte mask for the access size, anchored at byte 0.
	// No store means no strobe at all.
	always_comb begin
		case (store_code_i)
			STORE_SB: size_mask = STRB_W'(8'h01);
			STORE_SH: size_mask = STRB_W'(8'h03);
			STORE_SW: size_mask = STRB_W'(8'h0f);
			STORE_SD: size_mask = STRB_W'(8'hff);
			default:  size_mask = '0;
		endcase
	end

	// The mask and the data both move up by the byte offset.
	assign strb_mem_wr_o = size_mask << offset;
	assign data_mem_wr_o = data_rs2_i << {offset, 3'b000};

	// Enables follow the decoded codes directly.
	assign mem_wr_en_o = (store_code_i != STORE_NONE);
	assign mem_rd_en_o = (load_code_i != LOAD_NONE);

	// Read and write share one effective address.
	assign addr_mem_wr_o = addr_i;
	assign addr_mem_rd_o = addr_i;

endmodule

`default_nettype wire

/* verilog/ex_load_align.sv */
/*
 * Aligns the returned doubleword to the load address and extends it.
 * Memory returns data in the request cycle, on its natural byte lanes.
 * With no load the output is zero.
 */
`timescale 1ns/1ps
`default_nettype none

module ex_load_align import ex_pkg::*; (
	input  logic [XLEN-1:0] data_mem_i,
	input  logic [2:0]      offset_i,
	input  load_code_e      load_code_i,
	output logic [XLEN-1:0] load_data_o
);

	logic [XLEN-1:0] shifted;

	// Bring the addressed byte down to lane 0.
	assign shifted = data_mem_i >> {offset_i, 3'b000};

	// Keep the access size and fill the upper bits.
	always_comb begin
		case (load_code_i)
			LOAD_LB: begin
				load_data_o = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
			end
			LOAD_LH: begin
				load_data_o = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
			end
			LOAD_LW: begin
				load_data_o = {{(XLEN-32){shifted[31]}}, shifted[31:0]};
			end
			LOAD_LD: begin
				load_data_o = shifted;
			end
			// Unsigned loads zero-extend.
			LOAD_LBU: begin
				load_data_o = {{(XLEN-8){1'b0}}, shifted[7:0]};
			end
			LOAD_LHU: begin
				load_data_o = {{(XLEN-16){1'b0}}, shifted[15:0]};
			end
			LOAD_LWU: begin
				load_data_o = {{(XLEN-32){1'b0}}, shifted[31:0]};
			end
			default: begin
				load_data_o = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* verilog/ex_pipe_reg.sv */
/*
 * Single-entry pipeline register for any packed payload.
 * Asynchronous reset clears the whole payload to zero.
 * While hold_i is high the register keeps its value.
 */
`timescale 1ns/1ps
`default_nettype none

module ex_pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n_i,
	input  logic     hold_i,
	input  payload_t d_i,
	output payload_t q_o
);

	// Load every cycle unless the stage is frozen.
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			q_o <= '0;
		end else if (!hold_i) begin
			q_o <= d_i;
		end
	end

endmodule

`default_nettype wire

/* verilog/ex_stage.sv */
/*
 * Execute stage of the in-order RV64I pipeline, with the EX/MEM register.
 * Memory request outputs are combinational; writeback outputs lag by one clock.
 * No CSR, trap or hazard logic here; hold_code_i comes from outside.
 */
`timescale 1ns/1ps
`default_nettype none

module ex_stage import ex_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  hold_code_e           hold_code_i,
	// Operands. data_rs1_i is kept for the CSR path, which this stage omits.
	input  logic [XLEN-1:0]      data_rs1_i,
	input  logic [XLEN-1:0]      data_rs2_i,
	input  logic [XLEN-1:0]      alu_op_num1_i,
	input  logic [XLEN-1:0]      alu_op_num2_i,
	// Decoded controls.
	input  logic                 alu_add_sub_i,
	input  logic                 alu_shift_i,
	input  logic                 word_intercept_i,
	input  alu_op_e              alu_operation_i,
	input  load_code_e           load_code_i,
	input  store_code_e          store_code_i,
	// Destination register.
	input  logic [REG_IDX_W-1:0] addr_reg_wr_i,
	input  logic                 reg_wr_en_i,
	// Load data, returned in the request cycle.
	input  logic [XLEN-1:0]      data_mem_i,
	// Writeback side, registered.
	output logic [XLEN-1:0]      alu_result_o,
	output logic [XLEN-1:0]      data_reg_wr_o,
	output logic [REG_IDX_W-1:0] addr_reg_wr_o,
	output logic                 reg_wr_en_o,
	// Memory request side, combinational.
	output logic                 mem_wr_en_o,
	output logic                 mem_rd_en_o,
	output logic [XLEN-1:0]      data_mem_wr_o,
	output logic [STRB_W-1:0]    strb_mem_wr_o,
	output logic [ADDR_W-1:0]    addr_mem_wr_o,
	output logic [ADDR_W-1:0]    addr_mem_rd_o
);

	logic            hold;
	logic [XLEN-1:0] alu_result;
	logic [XLEN-1:0] alu_sum;
	logic [XLEN-1:0] load_data;
	wb_bus_t         wb_d;
	wb_bus_t         wb_q;

	// Freeze EX/MEM when the hold reaches this stage.
	assign hold = (hold_code_i >= HOLD_CODE_EX);

	ex_alu u_alu (
		.alu_op_num1_i    (alu_op_num1_i),
		.alu_op_num2_i    (alu_op_num2_i),
		.alu_operation_i  (alu_operation_i),
		.alu_add_sub_i    (alu_add_sub_i),
		.alu_shift_i      (alu_shift_i),
		.word_intercept_i (word_intercept_i),
		.alu_result_o     (alu_result),
		.alu_sum_o        (alu_sum)
	);

	// The raw sum is the effective address of loads and stores.
	ex_lsu_req u_lsu_req (
		.addr_i        (alu_sum),
		.data_rs2_i    (data_rs2_i),
		.load_code_i   (load_code_i),
		.store_code_i  (store_code_i),
		.mem_wr_en_o   (mem_wr_en_o),
		.mem_rd_en_o   (mem_rd_en_o),
		.data_mem_wr_o (data_mem_wr_o),
		.strb_mem_wr_o (strb_mem_wr_o),
		.addr_mem_wr_o (addr_mem_wr_o),
		.addr_mem_rd_o (addr_mem_rd_o)
	);

	ex_load_align u_load_align (
		.data_mem_i  (data_mem_i),
		.offset_i    (alu_sum[2:0]),
		.load_code_i (load_code_i),
		.load_data_o (load_data)
	);

	// Loads write the aligned memory value, everything else the ALU result.
	always_comb begin
		wb_d.alu_result  = alu_result;
		wb_d.data_reg_wr = (load_code_i != LOAD_NONE) ? load_data : alu_result;
		wb_d.addr_reg_wr = addr_reg_wr_i;
		wb_d.reg_wr_en   = reg_wr_en_i;
	end

	ex_pipe_reg #(
		.payload_t (wb_bus_t)
	) u_ex_mem (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.hold_i  (hold),
		.d_i     (wb_d),
		.q_o     (wb_q)
	);

	assign alu_result_o  = wb_q.alu_result;
	assign data_reg_wr_o = wb_q.data_reg_wr;
	assign addr_reg_wr_o = wb_q.addr_reg_wr;
	assign reg_wr_en_o   = wb_q.reg_wr_en;

endmodule

`default_nettype wire

/* verification/ex_stage_sva.sv */
/*
 * Bound checker for the execute stage; expected values come from the ISA rules.
 * Writeback checks compare against the previous cycle's expected values.
 * fail_count is read by the testbench through the bind hierarchy.
 */
`timescale 1ns/1ps
`default_nettype none

module ex_stage_sva import ex_pkg::*; (
	input logic                 clk,
	input logic                 rst_n_i,
	input hold_code_e           hold_code_i,
	input logic [XLEN-1:0]      data_rs2_i,
	input logic [XLEN-1:0]      alu_op_num1_i,
	input logic [XLEN-1:0]      alu_op_num2_i,
	input logic                 alu_add_sub_i,
	input logic                 alu_shift_i,
	input logic                 word_intercept_i,
	input alu_op_e              alu_operation_i,
	input load_code_e           load_code_i,
	input store_code_e          store_code_i,
	input logic [REG_IDX_W-1:0] addr_reg_wr_i,
	input logic                 reg_wr_en_i,
	input logic [XLEN-1:0]      data_mem_i,
	input logic [XLEN-1:0]      alu_result_o,
	input logic [XLEN-1:0]      data_reg_wr_o,
	input logic [REG_IDX_W-1:0] addr_reg_wr_o,
	input logic                 reg_wr_en_o,
	input logic                 mem_wr_en_o,
	input logic                 mem_rd_en_o,
	input logic [XLEN-1:0]      data_mem_wr_o,
	input logic [STRB_W-1:0]    strb_mem_wr_o,
	input logic [ADDR_W-1:0]    addr_mem_wr_o,
	input logic [ADDR_W-1:0]    addr_mem_rd_o
);

	int              fail_count = 0;
	logic [63:0]     addr;
	logic [63:0]     exp_alu;
	logic [63:0]     exp_data;
	logic [63:0]     exp_wdata;
	logic [7:0]      exp_strb;
	logic            hold;
	// Values captured at the previous clock edge.
	logic            prev_rst = 1'b0;
	logic            prev_hold = 1'b0;
	logic            prev_word = 1'b0;
	logic [63:0]     prev_alu = '0;
	logic [63:0]     prev_data = '0;
	logic [REG_IDX_W:0] prev_dest = '0;
	logic [133:0]    prev_wb = '0;

	// Reference ALU, written per operation on 32 or 64 bits.
	function automatic logic [63:0] ref_alu(input logic [63:0] a, input logic [63:0] b,
		input alu_op_e op, input logic sub, input logic sra, input logic word);
		logic [31:0]        r32;
		logic [63:0]        r64;
		logic signed [31:0] s32;
		logic signed [63:0] s64;
		s32 = a[31:0];
		s64 = a;
		case (op)
			ALU_ADD: begin
				r32 = sub ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
				r64 = sub ? a - b : a + b;
			end
			ALU_SLL: begin
				r32 = a[31:0] << b[4:0];
				r64 = a << b[5:0];
			end
			ALU_SLT: begin
				r32 = {31'b0, $signed(a[31:0]) < $signed(b[31:0])};
				r64 = {63'b0, $signed(a) < $signed(b)};
			end
			ALU_SLTU: begin
				r32 = {31'b0, a[31:0] < b[31:0]};
				r64 = {63'b0, a < b};
			end
			ALU_XOR: begin
				r32 = a[31:0] ^ b[31:0];
				r64 = a ^ b;
			end
			ALU_SRL: begin
				// The arithmetic shift copies the sign bit of the operand width.
				if (sra) begin
					r32 = s32 >>> b[4:0];
					r64 = s64 >>> b[5:0];
				end else begin
					r32 = a[31:0] >> b[4:0];
					r64 = a >> b[5:0];
				end
			end
			ALU_OR: begin
				r32 = a[31:0] | b[31:0];
				r64 = a | b;
			end
			default: begin
				r32 = a[31:0] & b[31:0];
				r64 = a & b;
			end
		endcase
		return word ? {{32{r32[31]}}, r32} : r64;
	endfunction

	// Reference load: take n bytes from the offset, then extend.
	function automatic logic [63:0] ref_load(input logic [63:0] d, input logic [2:0] off,
		input load_code_e code);
		logic [63:0] r;
		int          n;
		logic        sgn;
		r = '0;
		n = (code == LOAD_LB || code == LOAD_LBU) ? 1 :
			(code == LOAD_LH || code == LOAD_LHU) ? 2 :
			(code == LOAD_LW || code == LOAD_LWU) ? 4 : 8;
		sgn = (code == LOAD_LB || code == LOAD_LH || code == LOAD_LW);
		for (int i = 0; i < 8; i++) begin
			if (i < n && (int'(off) + i) < 8) begin
				r[8*i +: 8] = d[8*(int'(off) + i) +: 8];
			end else if (i >= n && sgn) begin
				r[8*i +: 8] = {8{r[8*n-1]}};
			end
		end
		return r;
	endfunction

	always_comb begin
		addr     = alu_op_num1_i + alu_op_num2_i;
		hold     = (hold_code_i >= HOLD_CODE_EX);
		exp_alu  = ref_alu(alu_op_num1_i, alu_op_num2_i, alu_operation_i, alu_add_sub_i,
			alu_shift_i, word_intercept_i);
		exp_data = (load_code_i == LOAD_NONE) ? exp_alu :
			ref_load(data_mem_i, addr[2:0], load_code_i);
		case (store_code_i)
			STORE_SB: exp_strb = 8'h01 << addr[2:0];
			STORE_SH: exp_strb = 8'h03 << addr[2:0];
			STORE_SW: exp_strb = 8'h0f << addr[2:0];
			STORE_SD: exp_strb = 8'hff << addr[2:0];
			default:  exp_strb = 8'h00;
		endcase
		exp_wdata = data_rs2_i << (8 * addr[2:0]);
	end

	always @(posedge clk) begin
		prev_rst  <= rst_n_i;
		prev_hold <= hold;
		prev_word <= word_intercept_i;
		prev_alu  <= exp_alu;
		prev_data <= exp_data;
		prev_dest <= {addr_reg_wr_i, reg_wr_en_i};
		prev_wb   <= {alu_result_o, data_reg_wr_o, addr_reg_wr_o, reg_wr_en_o};
	end

	a_reset: assert property (@(posedge clk) !rst_n_i |->
		(reg_wr_en_o == 1'b0 && alu_result_o == '0 && data_reg_wr_o == '0))
		else begin
			fail_count++;
			$error("Error: reset reg_wr_en_o=%h alu_result_o=%h data_reg_wr_o=%h",
				reg_wr_en_o, alu_result_o, data_reg_wr_o);
		end

	a_alu: assert property (@(posedge clk) disable iff (!rst_n_i)
		(prev_rst && !prev_hold) |-> alu_result_o == prev_alu)
		else begin
			fail_count++;
			$error("Error: alu_result_o got %h expected %h", alu_result_o, prev_alu);
		end

	a_word: assert property (@(posedge clk) disable iff (!rst_n_i)
		(prev_rst && !prev_hold && prev_word) |-> alu_result_o[63:32] == {32{alu_result_o[31]}})
		else begin
			fail_count++;
			$error("Error: alu_result_o upper half %h", alu_result_o);
		end

	a_data: assert property (@(posedge clk) disable iff (!rst_n_i)
		(prev_rst && !prev_hold) |-> data_reg_wr_o == prev_data)
		else begin
			fail_count++;
			$error("Error: data_reg_wr_o got %h expected %h", data_reg_wr_o, prev_data);
		end

	a_dest: assert property (@(posedge clk) disable iff (!rst_n_i)
		(prev_rst && !prev_hold) |-> {addr_reg_wr_o, reg_wr_en_o} == prev_dest)
		else begin
			fail_count++;
			$error("Error: addr_reg_wr_o,reg_wr_en_o got %h expected %h",
				{addr_reg_wr_o, reg_wr_en_o}, prev_dest);
		end

	a_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		(prev_rst && prev_hold) |->
		{alu_result_o, data_reg_wr_o, addr_reg_wr_o, reg_wr_en_o} == prev_wb)
		else begin
			fail_count++;
			$error("Error: writeback bundle changed under hold, now %h was %h",
				{alu_result_o, data_reg_wr_o, addr_reg_wr_o, reg_wr_en_o}, prev_wb);
		end

	a_store: assert property (@(posedge clk) disable iff (!rst_n_i)
		1'b1 |-> (strb_mem_wr_o == exp_strb && data_mem_wr_o == exp_wdata &&
		mem_wr_en_o == (store_code_i != STORE_NONE)))
		else begin
			fail_count++;
			$error("Error: strb_mem_wr_o=%h/%h data_mem_wr_o=%h/%h mem_wr_en_o=%h",
				strb_mem_wr_o, exp_strb, data_mem_wr_o, exp_wdata, mem_wr_en_o);
		end

	a_read: assert property (@(posedge clk) disable iff (!rst_n_i)
		1'b1 |-> (mem_rd_en_o == (load_code_i != LOAD_NONE) &&
		addr_mem_rd_o == addr && addr_mem_wr_o == addr))
		else begin
			fail_count++;
			$error("Error: mem_rd_en_o=%h addr_mem_rd_o=%h addr_mem_wr_o=%h expected %h",
				mem_rd_en_o, addr_mem_rd_o, addr_mem_wr_o, addr);
		end

endmodule

bind ex_stage ex_stage_sva sva_i (.*);

`default_nettype wire

/* verification/tb_ex_stage.sv */
/*
 * Testbench for the execute stage; the bound checker does all value checks.
 * Stimulus runs ALU, store, load and mixed phases with random hold levels.
 * Hold codes stay within the six defined levels.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage import ex_pkg::*; ();

	logic                 clk = 1'b0;
	logic                 rst_n_i;
	hold_code_e           hold_code_i;
	logic [XLEN-1:0]      data_rs1_i, data_rs2_i, alu_op_num1_i, alu_op_num2_i;
	logic                 alu_add_sub_i, alu_shift_i, word_intercept_i;
	alu_op_e              alu_operation_i;
	load_code_e           load_code_i;
	store_code_e          store_code_i;
	logic [REG_IDX_W-1:0] addr_reg_wr_i;
	logic                 reg_wr_en_i;
	logic [XLEN-1:0]      data_mem_i;
	logic [XLEN-1:0]      alu_result_o, data_reg_wr_o, data_mem_wr_o;
	logic [REG_IDX_W-1:0] addr_reg_wr_o;
	logic                 reg_wr_en_o, mem_wr_en_o, mem_rd_en_o;
	logic [STRB_W-1:0]    strb_mem_wr_o;
	logic [ADDR_W-1:0]    addr_mem_wr_o, addr_mem_rd_o;
	integer               seed = 32'h6a93;
	int                   timeout_count = 0;

	ex_stage dut_i (.*);

	always #50 clk = ~clk;

	function automatic logic [63:0] rand64();
		return {$random(seed), $random(seed)};
	endfunction

	// One cycle of random operands; the mode selects which codes may be active.
	task automatic drive_random(input int mode);
		@(posedge clk);
		alu_op_num1_i    <= rand64();
		alu_op_num2_i    <= ($random(seed) & 1) ? rand64() : 64'({$random(seed)} % 80);
		data_rs1_i       <= rand64();
		data_rs2_i       <= rand64();
		data_mem_i       <= rand64();
		alu_operation_i  <= alu_op_e'($random(seed) & 7);
		alu_add_sub_i    <= $random(seed) & 1;
		alu_shift_i      <= $random(seed) & 1;
		word_intercept_i <= $random(seed) & 1;
		addr_reg_wr_i    <= REG_IDX_W'($random(seed));
		reg_wr_en_i      <= $random(seed) & 1;
		store_code_i     <= (mode == 1 || mode == 3) ?
			store_code_e'({$random(seed)} % 5) : STORE_NONE;
		load_code_i      <= (mode == 2 || mode == 3) ?
			load_code_e'($random(seed) & 7) : LOAD_NONE;
		// Hold above EX about one cycle in four.
		if (($random(seed) & 3) == 0) begin
			hold_code_i <= hold_code_e'(3 + {$random(seed)} % 3);
		end else begin
			hold_code_i <= hold_code_e'({$random(seed)} % 3);
		end
	endtask

	// Waits for a level on an output, sampled at the falling edge.
	task automatic wait_for_level(input string what, input int sel, input int limit);
		bit seen;
		seen = 1'b0;
		for (int i = 0; i < limit && !seen; i++) begin
			@(negedge clk);
			seen = (sel == 0) ? reg_wr_en_o : mem_rd_en_o;
		end
		if (!seen) begin
			timeout_count++;
			$display("Timeout: %s did not go high within %0d cycles", what, limit);
		end
	endtask

	initial begin
		// Nonzero inputs during reset, so that the reset check means something.
		rst_n_i          = 1'b1;
		hold_code_i      = HOLD_NONE;
		data_rs1_i       = '1;
		data_rs2_i       = '1;
		alu_op_num1_i    = 64'h1234;
		alu_op_num2_i    = 64'h10;
		alu_add_sub_i    = 1'b0;
		alu_shift_i      = 1'b0;
		word_intercept_i = 1'b0;
		alu_operation_i  = ALU_ADD;
		load_code_i      = LOAD_NONE;
		store_code_i     = STORE_NONE;
		addr_reg_wr_i    = 5'd7;
		reg_wr_en_i      = 1'b1;
		data_mem_i       = '1;
		// Reset falls just after time zero, so the register sees a clean edge.
		#1;
		rst_n_i = 1'b0;
		repeat (5) @(posedge clk);
		rst_n_i <= 1'b1;
		wait_for_level("reg_wr_en_o after reset", 0, 10);

		for (int mode = 0; mode < 4; mode++) begin
			repeat (300) drive_random(mode);
		end

		// Directed load with no hold, then wait for the read request.
		@(posedge clk);
		hold_code_i <= HOLD_NONE;
		load_code_i <= LOAD_LD;
		wait_for_level("mem_rd_en_o for a load", 1, 10);
		repeat (2) @(posedge clk);

		$display("Checks done: %0d assertion failures, %0d timeouts",
			dut_i.sva_i.fail_count, timeout_count);
		if (dut_i.sva_i.fail_count == 0 && timeout_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_lsu_req.sv
verilog/ex_load_align.sv
verilog/ex_pipe_reg.sv
verilog/ex_stage.sv
verification/ex_stage_sva.sv
verification/tb_ex_stage.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the execute stage testbench with Verilator and runs it.
# Exit status is zero only when the run prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_ex_stage \
	-f verilog.f \
	-o tb_ex_stage_sim \
	&& ./obj_dir/tb_ex_stage_sim | tee /dev/stderr | grep -q "^TEST OK$" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
